//--- periph_xbar.f
+incdir+design
design/periph_xbar_pkg.sv
design/periph_req_demux.sv
design/periph_rr_arbiter.sv
design/periph_resp_router.sv
design/periph_xbar.sv
dv/tb_periph_slave.sv
dv/tb_periph_xbar.sv

//--- Bender.yml
package:
  name: periph_xbar

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/periph_xbar_pkg.sv
      - design/periph_req_demux.sv
      - design/periph_rr_arbiter.sv
      - design/periph_resp_router.sv
      - design/periph_xbar.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_periph_slave.sv
      - dv/tb_periph_xbar.sv

//--- dv/tb_periph_xbar.sv
// ****************************************
// Testbench of the peripheral crossbar:
// clock, reset, master stimulus, slave
// models, assertions and watchdog
// ****************************************

`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module tb_periph_xbar;

  import periph_xbar_pkg::*;

  localparam int NB_M   = `PX_NB_MASTERS;
  localparam int NB_S   = `PX_NB_SLAVES;
  localparam int N_RAND = 24;
  localparam int N_FAIR = 16;
  localparam int N_ACC  = N_RAND + N_FAIR;
  localparam int TOTAL  = NB_M * N_ACC;

  // Constant each slave model XORs into its read data
  localparam logic [NB_S-1:0][`PX_DATA_WIDTH-1:0] KEYS = {
    32'hE7E7_0003, 32'h3C3C_0002, 32'h5A5A_0001, 32'hA5A5_0000
  };

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [NB_M-1:0]       m_req;
  px_mreq_t [NB_M-1:0]   m_data;
  logic [NB_M-1:0]       m_gnt;
  logic [NB_M-1:0]       m_rvalid;
  px_resp_t [NB_M-1:0]   m_resp;
  logic [NB_S-1:0]       s_req;
  px_sreq_t [NB_S-1:0]   s_data;
  logic [NB_S-1:0]       s_gnt;
  logic [NB_S-1:0]       s_rvalid;
  px_resp_t [NB_S-1:0]   s_resp;
  logic [NB_S-1:0][31:0] slv_rand;

  // Reference state per master
  px_idx_t     exp_slv   [NB_M];
  px_sreq_t    exp_sreq  [NB_M];
  px_resp_t    head_resp [NB_M];
  px_resp_t    pend_q    [NB_M][$];
  int          pend_cnt  [NB_M];
  int          skip_cnt  [NB_M];
  bit          busy      [NB_M];
  int          sent      [NB_M];
  px_id_t      named;
  logic [31:0] rng    = 32'd17;
  int          errors = 0;
  int          rcvd   = 0;

  always #20 clk = ~clk;

  periph_xbar periph_xbar_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .m_req_i    (m_req),
    .m_data_i   (m_data),
    .m_gnt_o    (m_gnt),
    .m_rvalid_o (m_rvalid),
    .m_resp_o   (m_resp),
    .s_req_o    (s_req),
    .s_data_o   (s_data),
    .s_gnt_i    (s_gnt),
    .s_rvalid_i (s_rvalid),
    .s_resp_i   (s_resp)
  );

  for (genvar s = 0; s < NB_S; s++) begin : gen_slaves
    tb_periph_slave #(
      .KEY    (KEYS[s]),
      .IS_EXT (s == int'(PX_SLV_EXT))
    ) i_slave (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .req_i    (s_req[s]),
      .data_i   (s_data[s]),
      .rand_i   (slv_rand[s]),
      .gnt_o    (s_gnt[s]),
      .rvalid_o (s_rvalid[s]),
      .resp_o   (s_resp[s])
    );
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Window decode by cluster or alias byte and the peripheral range of addr[23:20]
  function automatic px_idx_t target_slave(input px_addr_t a);
    logic hit;
    hit = (a[31:24] == `PX_CLUSTER_BASE) ||
          ((`PX_ALIAS_EN != 0) && (a[31:24] == `PX_ALIAS_BASE));
    hit = hit && (a[23:20] >= `PX_PERIPH_LO) && (a[23:20] <= `PX_PERIPH_HI);
    return hit ? a[`PX_ROUTING_LSB +: $bits(px_idx_t)] : PX_SLV_EXT;
  endfunction

  // Mix of cluster, alias, off-range and fully random addresses
  function automatic px_addr_t pick_addr(input bit fair);
    px_addr_t    a;
    logic [31:0] r;
    logic [1:0]  kind;
    r    = next_rand();
    a    = next_rand();
    kind = fair ? 2'd0 : r[1:0];
    if (kind < 2'd2) begin
      a[31:24] = (kind == 2'd0) ? `PX_CLUSTER_BASE : `PX_ALIAS_BASE;
      a[23:20] = r[2] ? 4'(`PX_PERIPH_HI) : 4'(`PX_PERIPH_LO);
    end else if (kind == 2'd2) begin
      // Cluster or alias byte with addr[23:20] below or above the peripherals
      a[31:24] = r[3] ? `PX_ALIAS_BASE : `PX_CLUSTER_BASE;
      a[23:20] = r[4] ? 4'(`PX_PERIPH_LO - 1) - 4'(r[5]) :
                        4'(`PX_PERIPH_HI + 1) + 4'(r[9:6] % 12);
    end
    if (fair) begin
      a[`PX_ROUTING_LSB +: $bits(px_idx_t)] = PX_SLV_1;
    end
    return a;
  endfunction

  task automatic value_error(input string sig, input logic [79:0] exp_v,
                             input logic [79:0] act_v);
    errors++;
    $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, sig, exp_v, act_v);
  endtask

  task automatic plain_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  always_comb begin
    named = '0;
    for (int s = 0; s < NB_S; s++) begin
      named = named | (s_rvalid[s] ? s_resp[s].id : '0);
    end
  end

  // Handshakes, expected responses and fairness counters
  always @(posedge clk) begin
    px_resp_t exp_r;
    for (int s = 0; s < NB_S; s++) begin
      slv_rand[s] = next_rand();
    end
    for (int m = 0; m < NB_M; m++) begin
      if (m_rvalid[m]) begin
        rcvd++;
        if (pend_q[m].size() > 0) begin
          void'(pend_q[m].pop_front());
        end
      end
      if (m_req[m] && m_gnt[m]) begin
        exp_r.data = m_data[m].addr ^ KEYS[exp_slv[m]];
        exp_r.id   = px_id_t'(1) << m;
        exp_r.opc  = (exp_slv[m] == PX_SLV_EXT);
        pend_q[m].push_back(exp_r);
        busy[m]     = 1'b0;
        skip_cnt[m] = 0;
      end else if (m_req[m] && s_req[exp_slv[m]] && s_gnt[exp_slv[m]]) begin
        // Another master won the slave this one waits for
        skip_cnt[m]++;
      end else if (!m_req[m]) begin
        skip_cnt[m] = 0;
      end
      pend_cnt[m]  = pend_q[m].size();
      head_resp[m] = (pend_cnt[m] > 0) ? pend_q[m][0] : '0;
    end
  end

  initial begin : drive_masters
    px_addr_t    nxt      [NB_M];
    bit          have_nxt [NB_M];
    px_idx_t     tgt;
    logic [31:0] r;
    m_req = '0;
    m_data = '0;
    rst_n = 1'b0;
    for (int m = 0; m < NB_M; m++) begin
      exp_slv[m]  = '0;
      exp_sreq[m] = '0;
      busy[m]     = 1'b0;
      sent[m]     = 0;
      have_nxt[m] = 1'b0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    while (rcvd < TOTAL) begin
      for (int m = 0; m < NB_M; m++) begin
        if (!busy[m]) begin
          m_req[m] = 1'b0;
          if (sent[m] < N_ACC && !have_nxt[m]) begin
            nxt[m]      = pick_addr(sent[m] >= N_RAND);
            have_nxt[m] = 1'b1;
          end
          tgt = target_slave(nxt[m]);
          // A new target waits until older responses are back
          if (have_nxt[m] && (pend_cnt[m] == 0 || tgt == exp_slv[m])) begin
            r              = next_rand();
            m_data[m].addr = nxt[m];
            m_data[m].data = next_rand();
            m_data[m].we_n = r[0];
            m_data[m].be   = r[7:4];
            m_req[m]       = 1'b1;
            exp_slv[m]     = tgt;
            exp_sreq[m]    = '{mreq: m_data[m], id: px_id_t'(1) << m};
            busy[m]        = 1'b1;
            have_nxt[m]    = 1'b0;
            sent[m]++;
          end
        end
      end
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Run complete: %0d responses, %0d errors", rcvd, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TOTAL * 20 * 40);
    plain_error($sformatf("watchdog expired, %0d of %0d responses seen", rcvd, TOTAL));
    $display("Run aborted: %0d responses, %0d errors", rcvd, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Idle crossbar keeps slave requests and grants low
  idle_req_chk: assert property (@(posedge clk) (m_req == '0) |-> (s_req == '0))
    else value_error("s_req_o", '0, $sampled(s_req));
  idle_gnt_chk: assert property (@(posedge clk) (m_req == '0) |-> (m_gnt == '0))
    else value_error("m_gnt_o", '0, $sampled(m_gnt));

  rvalid_chk: assert property (@(posedge clk) disable iff (!rst_n) m_rvalid == named)
    else value_error("m_rvalid_o", $sampled(named), $sampled(m_rvalid));

  for (genvar m = 0; m < NB_M; m++) begin : gen_master_chk
    route_chk: assert property (@(posedge clk) disable iff (!rst_n)
        m_req[m] |-> s_req[exp_slv[m]])
      else value_error($sformatf("s_req_o[%0d]", $sampled(exp_slv[m])), 80'd1, 80'd0);
    payload_chk: assert property (@(posedge clk) disable iff (!rst_n)
        (m_req[m] && m_gnt[m]) |-> (s_data[exp_slv[m]] == exp_sreq[m]))
      else value_error($sformatf("s_data_o[%0d]", $sampled(exp_slv[m])),
                       $sampled(exp_sreq[m]), $sampled(s_data[exp_slv[m]]));
    // No grant without a request and a slave grant
    gnt_chk: assert property (@(posedge clk) disable iff (!rst_n)
        m_gnt[m] |-> (m_req[m] && s_gnt[exp_slv[m]]))
      else value_error($sformatf("m_gnt_o[%0d]", m), 80'd0, 80'd1);
    fair_chk: assert property (@(posedge clk) disable iff (!rst_n)
        m_req[m] |-> (skip_cnt[m] < NB_M))
      else plain_error($sformatf("master %0d passed over %0d times on slave %0d",
                                 m, $sampled(skip_cnt[m]), $sampled(exp_slv[m])));
    rdata_chk: assert property (@(posedge clk) disable iff (!rst_n)
        m_rvalid[m] |-> (m_resp[m] == head_resp[m]))
      else value_error($sformatf("m_resp_o[%0d]", m), $sampled(head_resp[m]),
                       $sampled(m_resp[m]));
    orphan_chk: assert property (@(posedge clk) disable iff (!rst_n)
        m_rvalid[m] |-> (pend_cnt[m] > 0))
      else plain_error($sformatf("master %0d got a response with nothing outstanding", m));
  end

endmodule

//--- dv/tb_periph_slave.sv
// ****************************************
// Behavioral peripheral slave: random
// grant, queued requests, id-tagged
// responses after 1 to 3 cycles
// ****************************************

`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module tb_periph_slave #(
  parameter logic [`PX_DATA_WIDTH-1:0] KEY    = '0,
  parameter bit                        IS_EXT = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  periph_xbar_pkg::px_sreq_t data_i,
  input  logic [31:0]               rand_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output periph_xbar_pkg::px_resp_t resp_o
);

  import periph_xbar_pkg::*;

  px_resp_t    resp_q[$];
  int unsigned due_q[$];
  int unsigned cycle = 0;
  int unsigned delay = 0;
  bit          live  = 1'b0;

  // Accept on the handshake edge and schedule the answer
  always @(posedge clk_i) begin
    px_resp_t r;
    live = rst_n_i;
    if (!rst_n_i) begin
      cycle = 0;
      resp_q.delete();
      due_q.delete();
    end else begin
      cycle++;
      if (req_i && gnt_o) begin
        r.data = data_i.mreq.addr ^ KEY;
        r.id   = data_i.id;
        r.opc  = IS_EXT;
        resp_q.push_back(r);
        due_q.push_back(cycle + delay);
      end
    end
  end

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    resp_o   = '0;
    forever begin
      @(negedge clk_i);
      gnt_o    = live && rand_i[0];
      delay    = rand_i[9:8] % 3;
      rvalid_o = 1'b0;
      resp_o   = '0;
      // Answers leave in order, one per cycle
      if (live && due_q.size() > 0 && due_q[0] <= cycle) begin
        rvalid_o = 1'b1;
        resp_o   = resp_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

endmodule

//--- design/periph_xbar.sv
// ****************************************
// Peripheral crossbar top level
// One request demux and one response
// router per master, one round-robin
// arbiter per slave port
// ****************************************

`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_xbar (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,

  // Master side
  input  logic [`PX_NB_MASTERS-1:0]                      m_req_i,
  input  periph_xbar_pkg::px_mreq_t [`PX_NB_MASTERS-1:0] m_data_i,
  output logic [`PX_NB_MASTERS-1:0]                      m_gnt_o,
  output logic [`PX_NB_MASTERS-1:0]                      m_rvalid_o,
  output periph_xbar_pkg::px_resp_t [`PX_NB_MASTERS-1:0] m_resp_o,

  // Slave side
  output logic [`PX_NB_SLAVES-1:0]                       s_req_o,
  output periph_xbar_pkg::px_sreq_t [`PX_NB_SLAVES-1:0]  s_data_o,
  input  logic [`PX_NB_SLAVES-1:0]                       s_gnt_i,
  input  logic [`PX_NB_SLAVES-1:0]                       s_rvalid_i,
  input  periph_xbar_pkg::px_resp_t [`PX_NB_SLAVES-1:0]  s_resp_i
);

  import periph_xbar_pkg::*;

  // Master-major view, as produced by the demuxes
  logic [`PX_NB_MASTERS-1:0][`PX_NB_SLAVES-1:0] ms_req;
  logic [`PX_NB_MASTERS-1:0][`PX_NB_SLAVES-1:0] ms_gnt;

  // Slave-major view, as used by the arbiters
  logic [`PX_NB_SLAVES-1:0][`PX_NB_MASTERS-1:0] sm_req;
  logic [`PX_NB_SLAVES-1:0][`PX_NB_MASTERS-1:0] sm_gnt;

  // Id-stamped payload of every master
  px_sreq_t [`PX_NB_MASTERS-1:0] m_sreq;

  for (genvar m = 0; m < `PX_NB_MASTERS; m++) begin : gen_masters
    periph_req_demux #(
      .MASTER_IDX (m)
    ) i_req_demux (
      .req_i      (m_req_i[m]),
      .data_i     (m_data_i[m]),
      .gnt_o      (m_gnt_o[m]),
      .slv_req_o  (ms_req[m]),
      .slv_data_o (m_sreq[m]),
      .slv_gnt_i  (ms_gnt[m])
    );

    periph_resp_router #(
      .MASTER_IDX (m)
    ) i_resp_router (
      .resp_valid_i (s_rvalid_i),
      .resp_i       (s_resp_i),
      .valid_o      (m_rvalid_o[m]),
      .resp_o       (m_resp_o[m])
    );
  end

  for (genvar s = 0; s < `PX_NB_SLAVES; s++) begin : gen_slaves
    // Transpose between the two views
    for (genvar m = 0; m < `PX_NB_MASTERS; m++) begin : gen_xpose
      assign sm_req[s][m] = ms_req[m][s];
      assign ms_gnt[m][s] = sm_gnt[s][m];
    end

    periph_rr_arbiter i_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (sm_req[s]),
      .data_i  (m_sreq),
      .gnt_o   (sm_gnt[s]),
      .req_o   (s_req_o[s]),
      .data_o  (s_data_o[s]),
      .gnt_i   (s_gnt_i[s])
    );
  end

endmodule

//--- design/periph_resp_router.sv
// ****************************************
// Per-master response router: picks the
// slave response whose one-hot id names
// this master
// ****************************************

`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_resp_router #(
  parameter int unsigned MASTER_IDX = 0
) (
  input  logic [`PX_NB_SLAVES-1:0]                      resp_valid_i,
  input  periph_xbar_pkg::px_resp_t [`PX_NB_SLAVES-1:0] resp_i,
  output logic                                          valid_o,
  output periph_xbar_pkg::px_resp_t                     resp_o
);

  import periph_xbar_pkg::*;

  localparam px_id_t OWN_ID = px_id_t'(1) << MASTER_IDX;

  logic [`PX_NB_SLAVES-1:0] hit;

  always_comb begin
    for (int s = 0; s < `PX_NB_SLAVES; s++) begin
      hit[s] = resp_valid_i[s] && (resp_i[s].id == OWN_ID);
    end
  end

  // AND-OR select, at most one slave answers this master per cycle
  always_comb begin
    resp_o = '0;
    for (int s = 0; s < `PX_NB_SLAVES; s++) begin
      resp_o = resp_o | ({$bits(px_resp_t){hit[s]}} & resp_i[s]);
    end
  end

  assign valid_o = |hit;

endmodule

//--- design/periph_rr_arbiter.sv
// ****************************************
// Per-slave round-robin arbiter with
// request payload selection
// Grant is combinational, the pointer
// moves past the winner on a handshake
// ****************************************

`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_rr_arbiter (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic [`PX_NB_MASTERS-1:0]                      req_i,
  input  periph_xbar_pkg::px_sreq_t [`PX_NB_MASTERS-1:0] data_i,
  output logic [`PX_NB_MASTERS-1:0]                      gnt_o,
  output logic                                           req_o,
  output periph_xbar_pkg::px_sreq_t                      data_o,
  input  logic                                           gnt_i
);

  localparam int unsigned NB_IN = `PX_NB_MASTERS;
  localparam int unsigned PTR_W = (NB_IN > 1) ? $clog2(NB_IN) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t ptr_q;
  ptr_t ptr_d;
  ptr_t win_idx;
  logic win_valid;
  logic handshake;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;

    win_valid = 1'b0;
    win_idx   = ptr_q;
    for (int unsigned off = 0; off < NB_IN; off++) begin
      cand = (int'(ptr_q) + off) % NB_IN;
      if (!win_valid && req_i[cand]) begin
        win_valid = 1'b1;
        win_idx   = ptr_t'(cand);
      end
    end
  end

  assign req_o  = win_valid;
  assign data_o = data_i[win_idx];

  // Choice is not locked, so the winner may change while gnt_i is low
  assign handshake = win_valid & gnt_i;

  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = handshake;
  end

  // Next pointer is one past the winner
  always_comb begin
    if (win_idx == ptr_t'(NB_IN - 1)) begin
      ptr_d = '0;
    end else begin
      ptr_d = win_idx + ptr_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (handshake) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

//--- design/periph_req_demux.sv
// ****************************************
// Per-master request demux: address
// decode to a slave index, one-hot id
// stamping and grant return
// ****************************************

`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_req_demux #(
  parameter int unsigned MASTER_IDX = 0
) (
  input  logic                         req_i,
  input  periph_xbar_pkg::px_mreq_t    data_i,
  output logic                         gnt_o,
  output logic [`PX_NB_SLAVES-1:0]     slv_req_o,
  output periph_xbar_pkg::px_sreq_t    slv_data_o,
  input  logic [`PX_NB_SLAVES-1:0]     slv_gnt_i
);

  import periph_xbar_pkg::*;

  logic [7:0] top_byte;
  logic [3:0] sub_field;
  logic       in_cluster;
  logic       in_periph;
  px_slave_e  sel;

  assign top_byte  = data_i.addr[`PX_ADDR_WIDTH-1 -: 8];
  assign sub_field = data_i.addr[23:20];

  // Own cluster, or the alias window when it is enabled
  assign in_cluster = (top_byte == `PX_CLUSTER_BASE) ||
                      ((`PX_ALIAS_EN != 0) && (top_byte == `PX_ALIAS_BASE));

  assign in_periph = (sub_field >= 4'(`PX_PERIPH_LO)) &&
                     (sub_field <= 4'(`PX_PERIPH_HI));

  always_comb begin
    if (in_cluster && in_periph) begin
      sel = px_slave_e'(data_i.addr[`PX_ROUTING_LSB +: $bits(px_idx_t)]);
    end else begin
      // Everything else leaves the cluster
      sel = PX_SLV_EXT;
    end
  end

  assign slv_data_o.mreq = data_i;
  assign slv_data_o.id   = px_id_t'(1) << MASTER_IDX;

  // Only the selected slave sees the request
  always_comb begin
    slv_req_o      = '0;
    slv_req_o[sel] = req_i;
  end

  assign gnt_o = slv_gnt_i[sel];

endmodule

//--- design/periph_xbar_pkg.sv
// ****************************************
// Types of the peripheral crossbar:
// slave index, master id, slave names,
// request and response structs
// ****************************************

`include "periph_xbar_cfg.svh"

package periph_xbar_pkg;

  typedef logic [`PX_ADDR_WIDTH-1:0]         px_addr_t;
  typedef logic [`PX_DATA_WIDTH-1:0]         px_data_t;
  typedef logic [$clog2(`PX_NB_SLAVES)-1:0]  px_idx_t;

  // One bit per master
  typedef logic [`PX_NB_MASTERS-1:0]         px_id_t;

  // Last port is the external slave, it takes everything off the window
  typedef enum px_idx_t {
    PX_SLV_0   = 2'd0,
    PX_SLV_1   = 2'd1,
    PX_SLV_2   = 2'd2,
    PX_SLV_EXT = 2'd3
  } px_slave_e;

  // Request as issued by a master
  typedef struct packed {
    px_addr_t                addr;
    px_data_t                data;
    logic                    we_n;  // low for a write
    logic [`PX_BE_WIDTH-1:0] be;
  } px_mreq_t;

  // Request as seen by a slave, tagged with the issuing master
  typedef struct packed {
    px_mreq_t mreq;
    px_id_t   id;
  } px_sreq_t;

  typedef struct packed {
    px_data_t data;
    px_id_t   id;
    logic     opc;  // error flag
  } px_resp_t;

endpackage

//--- design/periph_xbar_cfg.svh
// ****************************************
// Compile-time configuration of the
// peripheral crossbar: port counts, bus
// widths, routing field and address windows
// ****************************************

`ifndef PERIPH_XBAR_CFG_SVH
`define PERIPH_XBAR_CFG_SVH

// Four cores plus one master peripheral
`define PX_NB_MASTERS    5
`define PX_NB_SLAVES     4

`define PX_ADDR_WIDTH    32
`define PX_DATA_WIDTH    32
`define PX_BE_WIDTH      4

// Top address byte of this cluster and of its alias
`define PX_CLUSTER_BASE  8'h10
`define PX_ALIAS_EN      1
`define PX_ALIAS_BASE    8'h1b

// Range of addr[23:20] that holds the peripherals
`define PX_PERIPH_LO     2
`define PX_PERIPH_HI     3

// Slave index field starts here
`define PX_ROUTING_LSB   16

`endif
